// File: logic/test_mem_settings.svh
/*
 * Test memory settings
 * Physical size of the simulated memory and the widths of the
 * request and response message fields
 */
`ifndef TEST_MEM_SETTINGS_SVH
`define TEST_MEM_SETTINGS_SVH

// Physical memory size in bytes, addresses wrap at this size
`define MEM_NBYTES 1024

// Requester tag, returned unchanged with the response
`define OPAQUE_NBITS 8

// Request address and data word widths
`define ADDR_NBITS 32
`define DATA_NBITS 32

// Byte count field, zero stands for a full word
`define LEN_NBITS 2

// Opcode field width
`define OP_NBITS 3

`endif

// File: logic/test_mem_pkg.sv
/*
 * Test memory package
 * Opcodes, request and response message structs, storage index types
 */
`include "test_mem_settings.svh"

package test_mem_pkg;

  // ---------------------------------------------------------------------
  // Derived geometry
  // ---------------------------------------------------------------------

  localparam int BYTES_PER_WORD  = `DATA_NBITS / 8;
  localparam int NUM_BLOCKS      = `MEM_NBYTES / BYTES_PER_WORD;
  // Byte address bits kept after truncation to physical size
  localparam int PHYS_ADDR_NBITS = $clog2(`MEM_NBYTES);
  localparam int OFFSET_NBITS    = $clog2(BYTES_PER_WORD);
  localparam int BLK_ADDR_NBITS  = $clog2(NUM_BLOCKS);

  // ---------------------------------------------------------------------
  // Message types
  // ---------------------------------------------------------------------

  // Encoding 3'd2 is unused
  typedef enum logic [`OP_NBITS-1:0] {
    OP_READ    = 3'd0,
    OP_WRITE   = 3'd1,
    OP_AMO_ADD = 3'd3,
    OP_AMO_AND = 3'd4,
    OP_AMO_OR  = 3'd5
  } mem_op_e;

  typedef logic [`DATA_NBITS-1:0]    word_t;
  typedef logic [BLK_ADDR_NBITS-1:0] block_addr_t;
  typedef logic [BYTES_PER_WORD-1:0] byte_mask_t;

  // Request, 77 bits with the default settings
  typedef struct packed {
    mem_op_e                  op;
    logic [`OPAQUE_NBITS-1:0] opaque;
    logic [`ADDR_NBITS-1:0]   addr;
    logic [`LEN_NBITS-1:0]    len;
    word_t                    data;
  } mem_req_t;

  // Response, 45 bits with the default settings
  typedef struct packed {
    mem_op_e                  op;
    logic [`OPAQUE_NBITS-1:0] opaque;
    logic [`LEN_NBITS-1:0]    len;
    word_t                    data;
  } mem_resp_t;

endpackage

// File: logic/req_pipe_queue.sv
`timescale 1ns/1ps
/*
 * Request pipe queue
 * One registered request entry; accepts while full if the entry
 * leaves in the same cycle, so full rate is kept
 */

module req_pipe_queue import test_mem_pkg::*; (
  input  logic     clk,
  input  logic     reset,

  input  logic     enq_val_i,
  output logic     enq_rdy_o,
  input  mem_req_t enq_msg_i,

  output logic     deq_val_o,
  input  logic     deq_rdy_i,
  output mem_req_t deq_msg_o
);

  logic     full;
  logic     enq_fire;
  mem_req_t entry;

  // Ready passes through the dequeue side
  assign enq_rdy_o = !full || deq_rdy_i;
  assign enq_fire  = enq_val_i && enq_rdy_o;

  assign deq_val_o = full;
  assign deq_msg_o = entry;

  // Full flag
  always_ff @(posedge clk) begin
    if (!reset) begin
      full <= 1'b0;
    end else begin
      // Stays full on a simultaneous enqueue and dequeue
      full <= enq_fire || (full && !deq_rdy_i);
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (enq_fire) begin
      entry <= enq_msg_i;
    end
  end

endmodule

// File: logic/resp_bypass_queue.sv
`timescale 1ns/1ps
/*
 * Response bypass queue
 * Forwards a response straight through while empty and keeps it
 * in a one-entry buffer only when the consumer stalls
 */

module resp_bypass_queue import test_mem_pkg::*; (
  input  logic      clk,
  input  logic      reset,

  input  logic      enq_val_i,
  output logic      enq_rdy_o,
  input  mem_resp_t enq_msg_i,

  output logic      deq_val_o,
  input  logic      deq_rdy_i,
  output mem_resp_t deq_msg_o
);

  logic      full;
  logic      enq_fire;
  logic      capture;
  mem_resp_t entry;

  // Only an empty queue takes a new response
  assign enq_rdy_o = !full;
  assign enq_fire  = enq_val_i && enq_rdy_o;
  // Stored only when the bypassed response is not taken
  assign capture   = enq_fire && !deq_rdy_i;

  // Held entry has priority over the bypass path
  assign deq_val_o = full || enq_val_i;
  assign deq_msg_o = full ? entry : enq_msg_i;

  always_ff @(posedge clk) begin
    if (!reset) begin
      full <= 1'b0;
    end else if (capture) begin
      full <= 1'b1;
    end else if (deq_rdy_i) begin
      full <= 1'b0;
    end
  end

  // Buffer is stable while held
  always_ff @(posedge clk) begin
    if (capture) begin
      entry <= enq_msg_i;
    end
  end

endmodule

// File: logic/mem_port_exec.sv
`timescale 1ns/1ps
/*
 * Memory port execute stage
 * Splits the address, places write bytes in their lanes, computes
 * atomic results and builds the response from the old word
 */
`include "test_mem_settings.svh"

module mem_port_exec import test_mem_pkg::*; (
  input  mem_req_t    req_i,
  input  word_t       rd_word_i,
  output block_addr_t blk_addr_o,
  output byte_mask_t  wr_mask_o,
  output word_t       wr_word_o,
  output mem_resp_t   resp_o
);

  logic [PHYS_ADDR_NBITS-1:0] phys_addr;
  logic [OFFSET_NBITS-1:0]    offset;
  logic [`LEN_NBITS:0]        nbytes;
  word_t                      wr_shift;
  byte_mask_t                 lane_mask;
  word_t                      amo_word;

  // ---------------------------------------------------------------------
  // Address split
  // ---------------------------------------------------------------------

  // Bits above the physical size are dropped so addresses wrap
  assign phys_addr  = req_i.addr[PHYS_ADDR_NBITS-1:0];
  assign blk_addr_o = phys_addr[PHYS_ADDR_NBITS-1:OFFSET_NBITS];
  assign offset     = phys_addr[OFFSET_NBITS-1:0];

  // Length zero means a full word
  assign nbytes = (req_i.len == '0) ? (`LEN_NBITS+1)'(BYTES_PER_WORD)
                                    : {1'b0, req_i.len};

  // ---------------------------------------------------------------------
  // Write lanes
  // ---------------------------------------------------------------------

  assign wr_shift = req_i.data << {offset, 3'b000};

  // Lanes past the top of the word are simply not written
  always_comb begin
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      lane_mask[i] = (i >= int'(offset)) && (i < int'(offset) + int'(nbytes));
    end
  end

  // Atomics use the whole aligned word
  always_comb begin
    case (req_i.op)
      OP_AMO_ADD: amo_word = rd_word_i + req_i.data;
      OP_AMO_AND: amo_word = rd_word_i & req_i.data;
      default:    amo_word = rd_word_i | req_i.data;
    endcase
  end

  always_comb begin
    case (req_i.op)
      OP_WRITE: begin
        wr_mask_o = lane_mask;
        wr_word_o = wr_shift;
      end
      OP_AMO_ADD, OP_AMO_AND, OP_AMO_OR: begin
        wr_mask_o = '1;
        wr_word_o = amo_word;
      end
      // Reads and unused encodings leave memory alone
      default: begin
        wr_mask_o = '0;
        wr_word_o = wr_shift;
      end
    endcase
  end

  // ---------------------------------------------------------------------
  // Response
  // ---------------------------------------------------------------------

  assign resp_o.op     = req_i.op;
  assign resp_o.opaque = req_i.opaque;
  assign resp_o.len    = req_i.len;
  // Old word, addressed byte moved down to lane 0
  assign resp_o.data   = rd_word_i >> {offset, 3'b000};

endmodule

// File: logic/test_mem_array.sv
`timescale 1ns/1ps
/*
 * Test memory storage
 * Word array with two combinational read ports and two byte-masked
 * write ports; port 1 wins when both write the same byte
 */

module test_mem_array import test_mem_pkg::*; (
  input  logic        clk,

  // Each address serves both the read and the write of its side
  input  block_addr_t rd_addr0_i,
  input  block_addr_t rd_addr1_i,
  output word_t       rd_word0_o,
  output word_t       rd_word1_o,

  input  logic        we0_i,
  input  logic        we1_i,
  input  byte_mask_t  wr_mask0_i,
  input  byte_mask_t  wr_mask1_i,
  input  word_t       wr_word0_i,
  input  word_t       wr_word1_i
);

  word_t mem [NUM_BLOCKS];

  // ---------------------------------------------------------------------
  // Read ports
  // ---------------------------------------------------------------------

  // Same-cycle reads see the value before the edge
  assign rd_word0_o = mem[rd_addr0_i];
  assign rd_word1_o = mem[rd_addr1_i];

  // ---------------------------------------------------------------------
  // Write ports
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    // Port 0 first
    if (we0_i) begin
      for (int i = 0; i < BYTES_PER_WORD; i++) begin
        if (wr_mask0_i[i]) begin
          mem[rd_addr0_i][i*8 +: 8] <= wr_word0_i[i*8 +: 8];
        end
      end
    end
    // Port 1 last, so its bytes take effect on a collision
    if (we1_i) begin
      for (int i = 0; i < BYTES_PER_WORD; i++) begin
        if (wr_mask1_i[i]) begin
          mem[rd_addr1_i][i*8 +: 8] <= wr_word1_i[i*8 +: 8];
        end
      end
    end
  end

endmodule

// File: logic/test_mem_2port.sv
`timescale 1ns/1ps
/*
 * Two-port test memory
 * Each port runs a pipe queue, an execute stage and a bypass queue
 * around one shared word array
 */

module test_mem_2port import test_mem_pkg::*; (
  input  logic      clk,
  input  logic      reset,

  // Port 0
  input  logic      req0_val_i,
  output logic      req0_rdy_o,
  input  mem_req_t  req0_msg_i,
  output logic      resp0_val_o,
  input  logic      resp0_rdy_i,
  output mem_resp_t resp0_msg_o,

  // Port 1
  input  logic      req1_val_i,
  output logic      req1_rdy_o,
  input  mem_req_t  req1_msg_i,
  output logic      resp1_val_o,
  input  logic      resp1_rdy_i,
  output mem_resp_t resp1_msg_o
);

  // Execute stage signals, one set per port
  logic        m0_val;
  logic        m1_val;
  logic        m0_rdy;
  logic        m1_rdy;
  mem_req_t    m0_req;
  mem_req_t    m1_req;
  mem_resp_t   m0_resp;
  mem_resp_t   m1_resp;
  logic        fire0;
  logic        fire1;

  // Array side
  block_addr_t blk_addr0;
  block_addr_t blk_addr1;
  word_t       rd_word0;
  word_t       rd_word1;
  byte_mask_t  wr_mask0;
  byte_mask_t  wr_mask1;
  word_t       wr_word0;
  word_t       wr_word1;

  // ---------------------------------------------------------------------
  // Port 0 path
  // ---------------------------------------------------------------------

  req_pipe_queue u_req0_queue (
    .clk       (clk),
    .reset     (reset),
    .enq_val_i (req0_val_i),
    .enq_rdy_o (req0_rdy_o),
    .enq_msg_i (req0_msg_i),
    .deq_val_o (m0_val),
    .deq_rdy_i (m0_rdy),
    .deq_msg_o (m0_req)
  );

  mem_port_exec u_exec0 (
    .req_i      (m0_req),
    .rd_word_i  (rd_word0),
    .blk_addr_o (blk_addr0),
    .wr_mask_o  (wr_mask0),
    .wr_word_o  (wr_word0),
    .resp_o     (m0_resp)
  );

  // Memory commits once, on the cycle the response is accepted
  assign fire0 = m0_val && m0_rdy;

  resp_bypass_queue u_resp0_queue (
    .clk       (clk),
    .reset     (reset),
    .enq_val_i (m0_val),
    .enq_rdy_o (m0_rdy),
    .enq_msg_i (m0_resp),
    .deq_val_o (resp0_val_o),
    .deq_rdy_i (resp0_rdy_i),
    .deq_msg_o (resp0_msg_o)
  );

  // ---------------------------------------------------------------------
  // Port 1 path
  // ---------------------------------------------------------------------

  req_pipe_queue u_req1_queue (
    .clk       (clk),
    .reset     (reset),
    .enq_val_i (req1_val_i),
    .enq_rdy_o (req1_rdy_o),
    .enq_msg_i (req1_msg_i),
    .deq_val_o (m1_val),
    .deq_rdy_i (m1_rdy),
    .deq_msg_o (m1_req)
  );

  mem_port_exec u_exec1 (
    .req_i      (m1_req),
    .rd_word_i  (rd_word1),
    .blk_addr_o (blk_addr1),
    .wr_mask_o  (wr_mask1),
    .wr_word_o  (wr_word1),
    .resp_o     (m1_resp)
  );

  assign fire1 = m1_val && m1_rdy;

  resp_bypass_queue u_resp1_queue (
    .clk       (clk),
    .reset     (reset),
    .enq_val_i (m1_val),
    .enq_rdy_o (m1_rdy),
    .enq_msg_i (m1_resp),
    .deq_val_o (resp1_val_o),
    .deq_rdy_i (resp1_rdy_i),
    .deq_msg_o (resp1_msg_o)
  );

  // ---------------------------------------------------------------------
  // Shared storage
  // ---------------------------------------------------------------------

  test_mem_array u_array (
    .clk        (clk),
    .rd_addr0_i (blk_addr0),
    .rd_addr1_i (blk_addr1),
    .rd_word0_o (rd_word0),
    .rd_word1_o (rd_word1),
    .we0_i      (fire0),
    .we1_i      (fire1),
    .wr_mask0_i (wr_mask0),
    .wr_mask1_i (wr_mask1),
    .wr_word0_i (wr_word0),
    .wr_word1_i (wr_word1)
  );

endmodule

// File: dv/tb_test_mem.sv
`timescale 1ns/1ps
/*
 * Two-port test memory testbench
 * Directed tests checked against a byte-level reference model
 */
`include "test_mem_settings.svh"

module tb_test_mem import test_mem_pkg::*; ();

  // Cycles any single wait may take
  localparam int TIMEOUT = 20;

  logic      clk;
  logic      reset;
  logic      req0_val;
  logic      req0_rdy_o;
  mem_req_t  req0_msg;
  logic      resp0_val_o;
  logic      resp0_rdy;
  mem_resp_t resp0_msg_o;
  logic      req1_val;
  logic      req1_rdy_o;
  mem_req_t  req1_msg;
  logic      resp1_val_o;
  logic      resp1_rdy;
  mem_resp_t resp1_msg_o;

  // Reference copy of memory, one entry per byte
  logic [7:0] model_mem [`MEM_NBYTES];

  test_mem_2port u_test_mem_2port (
    .clk         (clk),
    .reset       (reset),
    .req0_val_i  (req0_val),
    .req0_rdy_o  (req0_rdy_o),
    .req0_msg_i  (req0_msg),
    .resp0_val_o (resp0_val_o),
    .resp0_rdy_i (resp0_rdy),
    .resp0_msg_o (resp0_msg_o),
    .req1_val_i  (req1_val),
    .req1_rdy_o  (req1_rdy_o),
    .req1_msg_i  (req1_msg),
    .resp1_val_o (resp1_val_o),
    .resp1_rdy_i (resp1_rdy),
    .resp1_msg_o (resp1_msg_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ---------------------------------------------------------------------
  // Checking and reference model
  // ---------------------------------------------------------------------

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // Data is skipped when the old word was never written
  task automatic compare_resp(input string name, input mem_resp_t exp, input mem_resp_t act,
                              input bit check_data);
    check_value({name, " op"}, word_t'(exp.op), word_t'(act.op));
    check_value({name, " opaque"}, word_t'(exp.opaque), word_t'(act.opaque));
    check_value({name, " len"}, word_t'(exp.len), word_t'(act.len));
    if (check_data) begin
      check_value({name, " data"}, exp.data, act.data);
    end
  endtask

  function automatic mem_req_t make_req(input mem_op_e op, input logic [`ADDR_NBITS-1:0] addr,
                                        input logic [`LEN_NBITS-1:0] len, input word_t data);
    mem_req_t req;
    word_t    tag;
    tag        = $urandom();
    req.op     = op;
    req.opaque = tag[`OPAQUE_NBITS-1:0];
    req.addr   = addr;
    req.len    = len;
    req.data   = data;
    return req;
  endfunction

  // Expected response, and the model updated as the memory would be
  function automatic mem_resp_t predict_resp(input mem_req_t req);
    mem_resp_t resp;
    word_t     old_word;
    word_t     new_word;
    int        phys;
    int        base;
    int        off;
    int        nbytes;
    phys   = int'(req.addr % `MEM_NBYTES);
    off    = phys % BYTES_PER_WORD;
    base   = phys - off;
    nbytes = (req.len == '0) ? BYTES_PER_WORD : int'(req.len);
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      old_word[i*8 +: 8] = model_mem[base + i];
    end
    resp.op     = req.op;
    resp.opaque = req.opaque;
    resp.len    = req.len;
    resp.data   = old_word >> (8 * off);
    new_word    = old_word;
    case (req.op)
      OP_WRITE: begin
        for (int i = 0; i < nbytes && off + i < BYTES_PER_WORD; i++) begin
          new_word[(off + i)*8 +: 8] = req.data[i*8 +: 8];
        end
      end
      // Atomics replace the whole aligned word
      OP_AMO_ADD: new_word = old_word + req.data;
      OP_AMO_AND: new_word = old_word & req.data;
      OP_AMO_OR:  new_word = old_word | req.data;
      default:    new_word = old_word;
    endcase
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      model_mem[base + i] = new_word[i*8 +: 8];
    end
    return resp;
  endfunction

  // ---------------------------------------------------------------------
  // Port drivers
  // ---------------------------------------------------------------------

  // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
  task automatic send_req(input int port, input mem_req_t req);
    int   cycles;
    logic rdy;
    cycles = 0;
    rdy    = 1'b0;
    if (port == 0) begin
      req0_val = 1'b1;
      req0_msg = req;
    end else begin
      req1_val = 1'b1;
      req1_msg = req;
    end
    while (!rdy) begin
      @(negedge clk);
      rdy = (port == 0) ? req0_rdy_o : req1_rdy_o;
      cycles++;
      if (!rdy && cycles > TIMEOUT) begin
        stop_with_failure($sformatf("Timed out waiting for request ready on port %0d", port));
      end
    end
    @(posedge clk);
    #1;
    if (port == 0) begin
      req0_val = 1'b0;
    end else begin
      req1_val = 1'b0;
    end
  endtask

  // Leaves response ready high
  task automatic recv_resp(input int port, output mem_resp_t resp);
    int   cycles;
    logic val;
    cycles = 0;
    val    = 1'b0;
    if (port == 0) begin
      resp0_rdy = 1'b1;
    end else begin
      resp1_rdy = 1'b1;
    end
    while (!val) begin
      @(negedge clk);
      val  = (port == 0) ? resp0_val_o : resp1_val_o;
      resp = (port == 0) ? resp0_msg_o : resp1_msg_o;
      cycles++;
      if (!val && cycles > TIMEOUT) begin
        stop_with_failure($sformatf("Timed out waiting for a response on port %0d", port));
      end
    end
    @(posedge clk);
    #1;
  endtask

  task automatic transact(input int port, input mem_req_t req, input string name,
                          input bit check_data);
    mem_resp_t exp;
    mem_resp_t act;
    exp = predict_resp(req);
    send_req(port, req);
    recv_resp(port, act);
    compare_resp(name, exp, act, check_data);
  endtask

  // ---------------------------------------------------------------------
  // Directed tests
  // ---------------------------------------------------------------------

  task automatic reset_state();
    @(negedge clk);
    check_value("reset resp0_val", 32'd0, word_t'(resp0_val_o));
    check_value("reset resp1_val", 32'd0, word_t'(resp1_val_o));
    check_value("reset req0_rdy", 32'd1, word_t'(req0_rdy_o));
    check_value("reset req1_rdy", 32'd1, word_t'(req1_rdy_o));
    @(posedge clk);
    #1;
  endtask

  task automatic full_word_write_read(input int port, input logic [`ADDR_NBITS-1:0] addr);
    string name;
    name = $sformatf("full_word port%0d", port);
    // First write sees an unknown old word
    transact(port, make_req(OP_WRITE, addr, 2'd0, $urandom()), name, 1'b0);
    transact(port, make_req(OP_WRITE, addr, 2'd0, $urandom()), name, 1'b1);
    transact(port, make_req(OP_READ, addr, 2'd0, 32'h0), name, 1'b1);
  endtask

  task automatic sub_write_read(input logic [`ADDR_NBITS-1:0] addr,
                                input logic [`LEN_NBITS-1:0] len);
    string name;
    name = $sformatf("sub_word addr %h len %0d", addr, len);
    transact(0, make_req(OP_WRITE, addr, len, $urandom()), name, 1'b1);
    transact(0, make_req(OP_READ, addr & ~32'h3, 2'd0, 32'h0), name, 1'b1);
  endtask

  task automatic sub_word_writes();
    transact(0, make_req(OP_WRITE, 32'h100, 2'd0, $urandom()), "sub_word init", 1'b0);
    sub_write_read(32'h100, 2'd1);
    sub_write_read(32'h103, 2'd1);
    sub_write_read(32'h101, 2'd2);
    sub_write_read(32'h102, 2'd2);
    sub_write_read(32'h100, 2'd3);
    sub_write_read(32'h101, 2'd3);
    // Wraps onto byte 0x102
    sub_write_read(`MEM_NBYTES + 32'h102, 2'd2);
    transact(0, make_req(OP_READ, 32'h102, 2'd2, 32'h0), "sub_word alias", 1'b1);
  endtask

  task automatic atomic_ops();
    transact(1, make_req(OP_WRITE, 32'h200, 2'd0, $urandom()), "atomic init", 1'b0);
    transact(1, make_req(OP_AMO_ADD, 32'h200, 2'd0, $urandom()), "amo_add", 1'b1);
    transact(1, make_req(OP_READ, 32'h200, 2'd0, 32'h0), "amo_add read", 1'b1);
    transact(1, make_req(OP_AMO_AND, 32'h200, 2'd0, $urandom()), "amo_and", 1'b1);
    transact(1, make_req(OP_READ, 32'h200, 2'd0, 32'h0), "amo_and read", 1'b1);
    // Unaligned address, still the whole word
    transact(1, make_req(OP_AMO_OR, 32'h202, 2'd0, $urandom()), "amo_or", 1'b1);
    transact(1, make_req(OP_READ, 32'h200, 2'd0, 32'h0), "amo_or read", 1'b1);
  endtask

  task automatic dual_port_traffic();
    fork
      transact(0, make_req(OP_WRITE, 32'h300, 2'd0, $urandom()), "dual write p0", 1'b0);
      transact(1, make_req(OP_WRITE, 32'h304, 2'd0, $urandom()), "dual write p1", 1'b0);
    join
    fork
      transact(0, make_req(OP_READ, 32'h304, 2'd0, 32'h0), "dual read p0", 1'b1);
      transact(1, make_req(OP_READ, 32'h300, 2'd0, 32'h0), "dual read p1", 1'b1);
    join
  endtask

  task automatic back_pressure_stream();
    mem_req_t  reqs [3];
    mem_resp_t exp  [3];
    mem_resp_t act;
    reqs[0] = make_req(OP_WRITE, 32'h40, 2'd0, $urandom());
    reqs[1] = make_req(OP_READ, 32'h40, 2'd0, 32'h0);
    reqs[2] = make_req(OP_AMO_OR, 32'h80, 2'd0, $urandom());
    for (int i = 0; i < 3; i++) begin
      exp[i] = predict_resp(reqs[i]);
    end
    resp0_rdy = 1'b0;
    send_req(0, reqs[0]);
    send_req(0, reqs[1]);
    req0_val = 1'b1;
    req0_msg = reqs[2];
    // First response held, second waits in the request queue
    repeat (4) begin
      @(negedge clk);
      check_value("back_pressure req_rdy", 32'd0, word_t'(req0_rdy_o));
      check_value("back_pressure resp_val", 32'd1, word_t'(resp0_val_o));
      compare_resp("back_pressure held", exp[0], resp0_msg_o, 1'b1);
    end
    @(posedge clk);
    #1;
    fork
      send_req(0, reqs[2]);
      for (int i = 0; i < 3; i++) begin
        recv_resp(0, act);
        compare_resp($sformatf("back_pressure resp %0d", i), exp[i], act, 1'b1);
      end
    join
  endtask

  initial begin
    void'($urandom(32'h962b));
    reset     = 1'b0;
    req0_val  = 1'b0;
    req0_msg  = '0;
    resp0_rdy = 1'b1;
    req1_val  = 1'b0;
    req1_msg  = '0;
    resp1_rdy = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b1;
    reset_state();
    full_word_write_read(0, 32'h40);
    full_word_write_read(1, 32'h80);
    sub_word_writes();
    atomic_ops();
    dual_port_traffic();
    back_pressure_stream();
    $display("Test passed");
    $finish;
  end

endmodule

// File: compile.f
+incdir+logic
logic/test_mem_pkg.sv
logic/req_pipe_queue.sv
logic/resp_bypass_queue.sv
logic/mem_port_exec.sv
logic/test_mem_array.sv
logic/test_mem_2port.sv
dv/tb_test_mem.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f compile.f \
  --top-module tb_test_mem -o tb_test_mem

out=$(./obj_dir/tb_test_mem 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1
